/* include/cnn_macros.svh */
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// Command stream framing
// Words per layer command
`define CMD_BURST_LEN       3
// Host bus word width
`define CMD_WORD_W          32

// Queue depths, also the initial credit counts of the two links
// Host side command FIFO, in words
`define CMD_FIFO_DEPTH      8
// Engine side descriptor queue, in descriptors
`define DESC_QUEUE_DEPTH    2

// Field widths
// Programmed layer count
`define CMD_COUNT_W         7
// Output element count reported per layer
`define LAYER_OUT_W         32

`endif

/* verilog/cnn_pkg.sv */
package cnn_pkg;

    // Layer operation codes, bits 2:0 of command word 0
    // Codes not listed here are rejected by the sequencer
    typedef enum logic [2:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_type_e;

    // Decoded layer command
    // Fields follow the three command words in order
    typedef struct packed {
        // Word 0
        op_type_e    op_type;
        logic [3:0]  stride;
        logic [7:0]  kernel;
        logic [7:0]  i_side;
        logic [7:0]  o_side;
        // Word 1
        logic [15:0] i_channel;
        logic [15:0] o_channel;
        // Word 2, low byte is reserved
        logic [7:0]  kernel_size;
        // Kernel times stride
        logic [15:0] stride2;
    } layer_desc_t;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        // Waiting for op enable
        SEQ_IDLE    = 3'b000,
        // Pulling command words from the FIFO
        SEQ_CMD_GET = 3'b001,
        // Op check and descriptor hand-off
        SEQ_ISSUE   = 3'b010,
        // Waiting for the engine to finish the layer
        SEQ_OP_RUN  = 3'b011,
        // All layers done, interrupt raised
        SEQ_FINISH  = 3'b100
    } seq_state_e;

endpackage

/* verilog/cmd_fifo.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cmd_fifo #(
    parameter type T     = logic [`CMD_WORD_W-1:0],
    parameter int  DEPTH = `CMD_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    // Write side
    input  logic i_wr,
    input  T     i_wr_data,
    // Read side, show-ahead
    input  logic i_rd,
    output T     o_rd_data,
    output logic o_not_empty
);

    // Pointer and occupancy widths
    // Occupancy needs one more state than the pointers
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage
    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Qualified handshakes
    logic do_wr;
    logic do_rd;

    // Writer is credit limited, so no full check here
    assign do_wr = i_wr;
    // Pop only counts when there is something to pop
    assign do_rd = i_rd && o_not_empty;

    assign o_not_empty = (count != '0);
    // Head entry is visible before the pop
    assign o_rd_data   = mem[rd_ptr];

    // Data array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers and occupancy
    // Wrap explicitly so a depth that is not a power of two also works
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/cmd_sequencer.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cmd_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    // Control
    input  logic                    i_op_en,
    input  logic [`CMD_COUNT_W-1:0] i_cmd_count,
    // Command FIFO, show-ahead
    input  logic                    i_fifo_not_empty,
    input  logic [`CMD_WORD_W-1:0]  i_fifo_data,
    output logic                    o_fifo_rd,
    // Descriptor issue towards the engine
    output logic                    o_desc_valid,
    output cnn_pkg::layer_desc_t    o_desc,
    // Engine feedback
    input  logic                    i_credit_return,
    input  logic                    i_layer_done,
    // Status
    output logic                    o_cmd_err,
    output logic                    o_irq,
    output cnn_pkg::seq_state_e     o_state
);

    import cnn_pkg::*;

    localparam int BURST_W  = $clog2(`CMD_BURST_LEN + 1);
    localparam int CREDIT_W = $clog2(`DESC_QUEUE_DEPTH + 1);

    seq_state_e state;
    seq_state_e next_state;

    // Index of the command word expected next
    logic [BURST_W-1:0]      word_idx;
    logic                    last_word;

    // Command being assembled / issued
    layer_desc_t             desc_q;
    logic                    op_ok;

    // Engine queue credits
    logic [CREDIT_W-1:0]     credit_cnt;
    logic                    issue;

    // Layers retired so far, errors included
    logic [`CMD_COUNT_W-1:0] done_cnt;
    logic [`CMD_COUNT_W-1:0] done_cnt_inc;
    logic                    count_hit;
    logic                    cmd_err;
    logic                    run_done;

    // Pop every word that is there while collecting
    // so the host credit pulse matches a real pop
    assign o_fifo_rd = (state == SEQ_CMD_GET) && i_fifo_not_empty;
    assign last_word = (word_idx == BURST_W'(`CMD_BURST_LEN - 1));

    // Supported ops only, OP_IDLE counts as an error too
    always_comb begin
        case (desc_q.op_type)
            OP_CONV_RELU,
            OP_MAX_POOL,
            OP_AVG_POOL: op_ok = 1'b1;
            default:     op_ok = 1'b0;
        endcase
    end

    // Issue needs a good op and a free queue slot
    assign issue     = (state == SEQ_ISSUE) && op_ok && (credit_cnt != '0);
    assign cmd_err   = (state == SEQ_ISSUE) && !op_ok;
    assign run_done  = (state == SEQ_OP_RUN) && i_layer_done;

    assign done_cnt_inc = done_cnt + 1'b1;
    // True when the layer retiring now is the last one programmed
    assign count_hit    = (done_cnt_inc == i_cmd_count);

    assign o_desc_valid = issue;
    assign o_desc       = desc_q;
    assign o_cmd_err    = cmd_err;
    assign o_state      = state;

    // State register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEQ_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: begin
                if (i_op_en) begin
                    next_state = SEQ_CMD_GET;
                end
            end
            SEQ_CMD_GET: begin
                // Third word popped, decode next cycle
                if (o_fifo_rd && last_word) begin
                    next_state = SEQ_ISSUE;
                end
            end
            SEQ_ISSUE: begin
                // Bad op is dropped and retired right here
                if (cmd_err) begin
                    next_state = count_hit ? SEQ_FINISH : SEQ_IDLE;
                end else if (issue) begin
                    next_state = SEQ_OP_RUN;
                end
            end
            SEQ_OP_RUN: begin
                if (i_layer_done) begin
                    next_state = count_hit ? SEQ_FINISH : SEQ_IDLE;
                end
            end
            // Only reset leaves FINISH
            SEQ_FINISH: next_state = SEQ_FINISH;
            default:    next_state = SEQ_IDLE;
        endcase
    end

    // Word counter, rewinds whenever we are not collecting
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_idx <= '0;
        end else if (state != SEQ_CMD_GET) begin
            word_idx <= '0;
        end else if (o_fifo_rd) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // Split each word into its fields
    always_ff @(posedge clk) begin
        if (o_fifo_rd) begin
            case (word_idx)
                BURST_W'(0): begin
                    desc_q.op_type <= op_type_e'(i_fifo_data[2:0]);
                    desc_q.stride  <= i_fifo_data[7:4];
                    desc_q.kernel  <= i_fifo_data[15:8];
                    desc_q.i_side  <= i_fifo_data[23:16];
                    desc_q.o_side  <= i_fifo_data[31:24];
                end
                BURST_W'(1): begin
                    desc_q.i_channel <= i_fifo_data[15:0];
                    desc_q.o_channel <= i_fifo_data[31:16];
                end
                BURST_W'(2): begin
                    desc_q.kernel_size <= i_fifo_data[15:8];
                    desc_q.stride2     <= i_fifo_data[31:16];
                end
                default: ;
            endcase
        end
    end

    // Credits: spend on issue, regain when the engine pops its queue
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= CREDIT_W'(`DESC_QUEUE_DEPTH);
        end else begin
            case ({issue, i_credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Retired layer count and sticky interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_cnt <= '0;
            o_irq    <= 1'b0;
        end else begin
            if (cmd_err || run_done) begin
                done_cnt <= done_cnt_inc;
            end
            // One cycle after reaching FINISH
            if (state == SEQ_FINISH) begin
                o_irq <= 1'b1;
            end
        end
    end

endmodule

/* verilog/layer_engine.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module layer_engine (
    input  logic                    clk,
    input  logic                    rst,
    // Descriptor input from the sequencer
    input  logic                    i_desc_valid,
    input  cnn_pkg::layer_desc_t    i_desc,
    // One pulse per descriptor taken off the queue
    output logic                    o_credit_return,
    // Layer completion
    output logic                    o_layer_done,
    output cnn_pkg::op_type_e       o_layer_op,
    output logic [`LAYER_OUT_W-1:0] o_layer_outputs
);

    import cnn_pkg::*;

    // Queue head
    logic        q_not_empty;
    layer_desc_t q_head;

    // Pop one cycle after an idle engine sees a head entry
    logic        pop_arm;
    logic        busy;
    // Room for o_side + 1
    logic [8:0]  run_cnt;
    logic        run_last;
    // Layer in progress
    layer_desc_t cur_desc;

    // Descriptor queue, sized to the sequencer's credit count
    cmd_fifo #(
        .T     (layer_desc_t),
        .DEPTH (`DESC_QUEUE_DEPTH)
    ) u_desc_q (
        .clk         (clk),
        .rst         (rst),
        .i_wr        (i_desc_valid),
        .i_wr_data   (i_desc),
        .i_rd        (pop_arm),
        .o_rd_data   (q_head),
        .o_not_empty (q_not_empty)
    );

    // Slot freed at pop time
    assign o_credit_return = pop_arm;
    assign run_last        = busy && (run_cnt == '0);

    // Run control
    // busy lasts o_side + 2 cycles after the pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pop_arm      <= 1'b0;
            busy         <= 1'b0;
            run_cnt      <= '0;
            o_layer_done <= 1'b0;
        end else begin
            pop_arm      <= q_not_empty && !busy && !pop_arm;
            o_layer_done <= 1'b0;
            if (pop_arm) begin
                busy    <= 1'b1;
                run_cnt <= {1'b0, q_head.o_side} + 9'd1;
            end else if (run_last) begin
                busy         <= 1'b0;
                o_layer_done <= 1'b1;
            end else if (busy) begin
                run_cnt <= run_cnt - 1'b1;
            end
        end
    end

    // Latch the popped descriptor
    always_ff @(posedge clk) begin
        if (pop_arm) begin
            cur_desc <= q_head;
        end
    end

    // Result registered in the last run cycle, valid with the done pulse
    // o_side * o_side * o_channel fits in 32 bits
    always_ff @(posedge clk) begin
        if (run_last) begin
            o_layer_op      <= cur_desc.op_type;
            o_layer_outputs <= `LAYER_OUT_W'(cur_desc.o_side)
                             * `LAYER_OUT_W'(cur_desc.o_side)
                             * `LAYER_OUT_W'(cur_desc.o_channel);
        end
    end

endmodule

/* verilog/cnn_ctrl_top.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module cnn_ctrl_top (
    input  logic                    clk,
    input  logic                    rst,
    // Host control
    input  logic                    i_op_en,
    input  logic [`CMD_COUNT_W-1:0] i_cmd_count,
    // Host command writes, credit limited
    input  logic                    i_cmd_wr,
    input  logic [`CMD_WORD_W-1:0]  i_cmd_data,
    output logic                    o_cmd_credit,
    // Layer results
    output logic                    o_layer_done,
    output cnn_pkg::op_type_e       o_layer_op,
    output logic [`LAYER_OUT_W-1:0] o_layer_outputs,
    // Status
    output logic                    o_cmd_err,
    output logic                    o_irq,
    output cnn_pkg::seq_state_e     o_state
);

    import cnn_pkg::*;

    // Command FIFO to sequencer
    logic                   fifo_not_empty;
    logic [`CMD_WORD_W-1:0] fifo_data;
    logic                   fifo_rd;

    // Sequencer to engine
    logic                   desc_valid;
    layer_desc_t            desc;
    logic                   credit_return;

    // Every popped word hands one credit back to the host
    assign o_cmd_credit = fifo_rd;

    // Host command words
    cmd_fifo #(
        .T     (logic [`CMD_WORD_W-1:0]),
        .DEPTH (`CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk         (clk),
        .rst         (rst),
        .i_wr        (i_cmd_wr),
        .i_wr_data   (i_cmd_data),
        .i_rd        (fifo_rd),
        .o_rd_data   (fifo_data),
        .o_not_empty (fifo_not_empty)
    );

    // Command decode and layer bookkeeping
    cmd_sequencer u_seq (
        .clk              (clk),
        .rst              (rst),
        .i_op_en          (i_op_en),
        .i_cmd_count      (i_cmd_count),
        .i_fifo_not_empty (fifo_not_empty),
        .i_fifo_data      (fifo_data),
        .o_fifo_rd        (fifo_rd),
        .o_desc_valid     (desc_valid),
        .o_desc           (desc),
        .i_credit_return  (credit_return),
        .i_layer_done     (o_layer_done),
        .o_cmd_err        (o_cmd_err),
        .o_irq            (o_irq),
        .o_state          (o_state)
    );

    // Layer timing model
    layer_engine u_engine (
        .clk             (clk),
        .rst             (rst),
        .i_desc_valid    (desc_valid),
        .i_desc          (desc),
        .o_credit_return (credit_return),
        .o_layer_done    (o_layer_done),
        .o_layer_op      (o_layer_op),
        .o_layer_outputs (o_layer_outputs)
    );

endmodule

/* testbench/tb_cnn_ctrl.sv */
`timescale 1ns/1ps
`include "cnn_macros.svh"

module tb_cnn_ctrl;

    import cnn_pkg::*;

    // Random mix first, then a burst of one-row layers
    localparam int PHASE1_CMDS = 20;
    localparam int PHASE2_CMDS = 8;
    localparam int TOTAL_CMDS  = PHASE1_CMDS + PHASE2_CMDS;

    logic                    clk;
    logic                    rst;
    logic                    i_op_en;
    logic [`CMD_COUNT_W-1:0] i_cmd_count;
    logic                    i_cmd_wr;
    logic [`CMD_WORD_W-1:0]  i_cmd_data;
    logic                    o_cmd_credit;
    logic                    o_layer_done;
    op_type_e                o_layer_op;
    logic [`LAYER_OUT_W-1:0] o_layer_outputs;
    logic                    o_cmd_err;
    logic                    o_irq;
    seq_state_e              o_state;

    // Command list with three words per command
    logic [31:0] cmd_words [TOTAL_CMDS*3];
    logic [2:0]  cmd_op    [TOTAL_CMDS];
    logic [7:0]  cmd_side  [TOTAL_CMDS];
    logic [15:0] cmd_chan  [TOTAL_CMDS];

    // Expected retire events in issue order, and the host's pending words
    logic        exp_is_err  [$];
    logic [2:0]  exp_op      [$];
    logic [31:0] exp_outputs [$];
    logic [31:0] host_words  [$];

    int          mismatch_errors = 0;
    int          other_errors    = 0;
    int          phase_cmds      = 0;
    int          retired         = 0;
    int          credits_seen    = 0;
    int          cycle_count     = 0;
    int          cycle_limit     = 0;
    logic        irq_prev        = 1'b0;
    int unsigned seed;

    cnn_ctrl_top uut (
        .clk             (clk),
        .rst             (rst),
        .i_op_en         (i_op_en),
        .i_cmd_count     (i_cmd_count),
        .i_cmd_wr        (i_cmd_wr),
        .i_cmd_data      (i_cmd_data),
        .o_cmd_credit    (o_cmd_credit),
        .o_layer_done    (o_layer_done),
        .o_layer_op      (o_layer_op),
        .o_layer_outputs (o_layer_outputs),
        .o_cmd_err       (o_cmd_err),
        .o_irq           (o_irq),
        .o_state         (o_state)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // Only conv+relu, max pool and avg pool run on the engine
    function automatic logic op_is_valid(input logic [2:0] op);
        case (op)
            3'b001, 3'b100, 3'b101: return 1'b1;
            default:                return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        mismatch_errors++;
        $display("Mismatch at %0d ns: %s expected %0d got %0d", $time, name, exp_v, act_v);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    // Random command list that also sizes the watchdog
    task automatic build_commands();
        logic [2:0] op;
        logic [7:0] side;
        logic [15:0] chan;
        int side_sum;
        side_sum = 0;
        for (int i = 0; i < TOTAL_CMDS; i++) begin
            if (i == 0) begin
                op = 3'b000;
            end else if (i == 1) begin
                op = 3'b110;
            end else if (i >= PHASE1_CMDS || ($urandom % 4) != 0) begin
                case ($urandom % 3)
                    0:       op = 3'b001;
                    1:       op = 3'b100;
                    default: op = 3'b101;
                endcase
            end else begin
                // Any code and often an invalid one
                op = 3'($urandom % 8);
            end
            side = (i >= PHASE1_CMDS) ? 8'd1 : 8'(1 + $urandom % 12);
            chan = 16'(1 + $urandom % 20);
            cmd_op[i]   = op;
            cmd_side[i] = side;
            cmd_chan[i] = chan;
            // Word 0 o_side, i_side, kernel, stride, op
            cmd_words[3*i]   = {side, 8'($urandom), 8'($urandom), 4'($urandom), 1'b0, op};
            // Word 1 o_channel, i_channel
            cmd_words[3*i+1] = {chan, 16'($urandom)};
            // Word 2 stride2, kernel_size, reserved byte
            cmd_words[3*i+2] = {16'($urandom), 8'($urandom), 8'h00};
            side_sum += side + 10;
        end
        cycle_limit = 40 * side_sum;
    endtask

    // Queue up words and expected results of one phase
    task automatic load_phase(input int first, input int count);
        exp_is_err.delete();
        exp_op.delete();
        exp_outputs.delete();
        host_words.delete();
        for (int i = first; i < first + count; i++) begin
            for (int w = 0; w < `CMD_BURST_LEN; w++) begin
                host_words.push_back(cmd_words[3*i+w]);
            end
            exp_is_err.push_back(!op_is_valid(cmd_op[i]));
            exp_op.push_back(cmd_op[i]);
            exp_outputs.push_back(32'(cmd_side[i]) * 32'(cmd_side[i]) * 32'(cmd_chan[i]));
        end
    endtask

    // Reset for 2 cycles, check the reset state, then stream one phase
    task automatic run_phase(input int first, input int count);
        int host_credit;
        @(negedge clk);
        rst         = 1'b1;
        i_cmd_wr    = 1'b0;
        i_cmd_count = `CMD_COUNT_W'(count);
        phase_cmds  = count;
        load_phase(first, count);
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!o_irq) else report_mismatch("o_irq", 0, o_irq);
        assert (!o_layer_done) else report_mismatch("o_layer_done", 0, o_layer_done);
        assert (!o_cmd_err) else report_mismatch("o_cmd_err", 0, o_cmd_err);
        assert (o_state == SEQ_IDLE) else report_mismatch("o_state", SEQ_IDLE, o_state);
        rst = 1'b0;
        // Host writes one word per cycle while it holds a credit
        host_credit = `CMD_FIFO_DEPTH;
        while (!o_irq) begin
            @(negedge clk);
            if (o_cmd_credit) begin
                host_credit++;
            end
            assert (host_credit <= `CMD_FIFO_DEPTH)
                else report_failure("host got back more credits than the FIFO depth");
            if (host_credit > 0 && host_words.size() > 0) begin
                i_cmd_wr   = 1'b1;
                i_cmd_data = host_words.pop_front();
                host_credit--;
            end else begin
                i_cmd_wr = 1'b0;
            end
        end
        i_cmd_wr = 1'b0;
        // Quiet tail where irq must hold and nothing else may retire
        repeat (10) @(negedge clk);
        assert (credits_seen == 3 * count)
            else report_mismatch("o_cmd_credit pulses", 3 * count, credits_seen);
        assert (retired == count) else report_mismatch("retired commands", count, retired);
        assert (exp_is_err.size() == 0) else report_failure("some commands never retired");
        assert (host_words.size() == 0) else report_failure("host words left unsent");
    endtask

    // Response checks sampled in the middle of the low phase
    always @(negedge clk) begin
        logic       is_err;
        logic [2:0] op;
        logic [31:0] outs;
        #1;
        if (rst) begin
            retired      = 0;
            credits_seen = 0;
            irq_prev     = 1'b0;
        end else begin
            if (o_cmd_credit) begin
                credits_seen++;
            end
            if (o_cmd_err) begin
                if (exp_is_err.size() == 0) begin
                    report_failure("o_cmd_err pulse with no command pending");
                end else begin
                    is_err = exp_is_err.pop_front();
                    op     = exp_op.pop_front();
                    outs   = exp_outputs.pop_front();
                    assert (is_err)
                        else report_failure($sformatf("o_cmd_err for valid op %0d", op));
                    retired++;
                end
            end
            if (o_layer_done) begin
                if (exp_is_err.size() == 0) begin
                    report_failure("o_layer_done with no command pending");
                end else begin
                    is_err = exp_is_err.pop_front();
                    op     = exp_op.pop_front();
                    outs   = exp_outputs.pop_front();
                    assert (!is_err)
                        else report_failure($sformatf("o_layer_done for invalid op %0d", op));
                    assert (3'(o_layer_op) == op)
                        else report_mismatch("o_layer_op", op, o_layer_op);
                    assert (o_layer_outputs == outs)
                        else report_mismatch("o_layer_outputs", outs, o_layer_outputs);
                    retired++;
                end
            end
            // Sticky interrupt only after the last programmed command
            assert (!o_irq || retired == phase_cmds)
                else report_failure("o_irq high before all commands completed");
            assert (!irq_prev || o_irq) else report_failure("o_irq dropped without a reset");
            irq_prev = o_irq;
        end
    end

    // Watchdog on total cycles
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        i_op_en     = 1'b0;
        i_cmd_count = '0;
        i_cmd_wr    = 1'b0;
        i_cmd_data  = '0;
        seed        = 32'hc1a6;
        void'($urandom(seed));
        build_commands();
        // Held high so every return to idle fetches the next command
        i_op_en = 1'b1;
        run_phase(0, PHASE1_CMDS);
        // Burst of short layers back to back
        run_phase(PHASE1_CMDS, PHASE2_CMDS);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
verilog/cnn_pkg.sv
verilog/cmd_fifo.sv
verilog/cmd_sequencer.sv
verilog/layer_engine.sv
verilog/cnn_ctrl_top.sv
testbench/tb_cnn_ctrl.sv
